/* flist.f */
+incdir+hw
hw/raster_types_pkg.sv
hw/raster_ctrl_pkg.sv
hw/float_to_fixed.sv
hw/attribute_converter.sv
hw/span_pixel_counter.sv
hw/span_sequencer.sv
hw/raster_fragment_top.sv
verif/tb_raster_fragment.sv

/* hw/attribute_converter.sv */
////////////////////////////////////////
// Converts all fragment attributes to fixed point
// Latency 2 enabled cycles, tags follow in step
// Depth Q16.16, texture S16.15, colour saturated
// Colours of 1.0 or more and negatives give all ones
////////////////////////////////////////
`timescale 1ns/1ns
`include "raster_config.svh"

module attribute_converter
(
    input  logic                                aclk,
    input  logic                                rst_n,
    input  logic                                ce,
    input  logic                                in_valid,
    input  raster_types_pkg::screen_pos_t       in_x,
    input  raster_types_pkg::screen_pos_t       in_y,
    input  logic [`RASTER_INDEX_WIDTH-1:0]      in_index,
    input  logic                                in_last,
    input  raster_types_pkg::float_word_u       in_depth_z,
    input  raster_types_pkg::float_word_u       in_tex_s,
    input  raster_types_pkg::float_word_u       in_tex_t,
    input  raster_types_pkg::float_word_u       in_color_r,
    input  raster_types_pkg::float_word_u       in_color_g,
    input  raster_types_pkg::float_word_u       in_color_b,
    input  raster_types_pkg::float_word_u       in_color_a,
    output logic                                out_valid,
    output raster_types_pkg::screen_pos_t       out_x,
    output raster_types_pkg::screen_pos_t       out_y,
    output logic [`RASTER_INDEX_WIDTH-1:0]      out_index,
    output logic                                out_last,
    output raster_types_pkg::fixed_word_t       out_depth_z,
    output raster_types_pkg::fixed_word_t       out_tex_s,
    output raster_types_pkg::fixed_word_t       out_tex_t,
    output raster_types_pkg::sub_pixel_t        out_color_r,
    output raster_types_pkg::sub_pixel_t        out_color_g,
    output raster_types_pkg::sub_pixel_t        out_color_b,
    output raster_types_pkg::sub_pixel_t        out_color_a
);
    import raster_types_pkg::*;

    localparam int SUB_W = `RASTER_SUB_PIXEL_WIDTH;
    localparam int COLOR_FRAC = `RASTER_COLOR_FRAC_BITS;
    localparam int TAG_W = 2 * `RASTER_SCREEN_POS_WIDTH + `RASTER_INDEX_WIDTH + 1;

    fixed_word_t      color_r_fix;
    fixed_word_t      color_g_fix;
    fixed_word_t      color_b_fix;
    fixed_word_t      color_a_fix;
    logic [1:0]       valid_q;
    logic [TAG_W-1:0] tag_s1;
    logic [TAG_W-1:0] tag_s2;

    // Integer part set means 1.0 or above, or negative
    function automatic sub_pixel_t saturate_color(input fixed_word_t word);
        if (|word[31:COLOR_FRAC])
            return '1;
        else
            return word[COLOR_FRAC-SUB_W +: SUB_W];
    endfunction

    ////////////////////////////////////////
    // Float conversion
    ////////////////////////////////////////
    float_to_fixed #(.FRAC_BITS(`RASTER_DEPTH_FRAC_BITS)) i_conv_depth_z
        (.aclk(aclk), .ce(ce), .in_word(in_depth_z), .out_word(out_depth_z));
    float_to_fixed #(.FRAC_BITS(`RASTER_TEX_FRAC_BITS)) i_conv_tex_s
        (.aclk(aclk), .ce(ce), .in_word(in_tex_s), .out_word(out_tex_s));
    float_to_fixed #(.FRAC_BITS(`RASTER_TEX_FRAC_BITS)) i_conv_tex_t
        (.aclk(aclk), .ce(ce), .in_word(in_tex_t), .out_word(out_tex_t));
    float_to_fixed #(.FRAC_BITS(COLOR_FRAC)) i_conv_color_r
        (.aclk(aclk), .ce(ce), .in_word(in_color_r), .out_word(color_r_fix));
    float_to_fixed #(.FRAC_BITS(COLOR_FRAC)) i_conv_color_g
        (.aclk(aclk), .ce(ce), .in_word(in_color_g), .out_word(color_g_fix));
    float_to_fixed #(.FRAC_BITS(COLOR_FRAC)) i_conv_color_b
        (.aclk(aclk), .ce(ce), .in_word(in_color_b), .out_word(color_b_fix));
    float_to_fixed #(.FRAC_BITS(COLOR_FRAC)) i_conv_color_a
        (.aclk(aclk), .ce(ce), .in_word(in_color_a), .out_word(color_a_fix));

    ////////////////////////////////////////
    // Valid and tag delay, matches converter
    ////////////////////////////////////////
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 2'b00;
        else if (ce)
            valid_q <= {valid_q[0], in_valid};
    end

    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            tag_s1 <= {in_x, in_y, in_index, in_last};
            tag_s2 <= tag_s1;
        end
    end

    assign out_valid = valid_q[1];
    assign {out_x, out_y, out_index, out_last} = tag_s2;

    // Colour channels
    assign out_color_r = saturate_color(color_r_fix);
    assign out_color_g = saturate_color(color_g_fix);
    assign out_color_b = saturate_color(color_b_fix);
    assign out_color_a = saturate_color(color_a_fix);

    out_valid_known : assert property (
        @(posedge aclk) disable iff (!rst_n) !$isunknown(out_valid)
    );

endmodule

/* hw/float_to_fixed.sv */
////////////////////////////////////////
// Float to signed fixed-point, 2 cycles
// Truncates toward zero, denormals give 0
// Overflow, inf and NaN saturate by sign
// Stalls completely while ce is low
////////////////////////////////////////
`timescale 1ns/1ns

module float_to_fixed #(
    parameter int FRAC_BITS = 16
)
(
    input  logic                          aclk,
    input  logic                          ce,
    input  raster_types_pkg::float_word_u in_word,
    output raster_types_pkg::fixed_word_t out_word
);
    import raster_types_pkg::*;

    // Exponent bias plus mantissa width, less the fraction bits
    localparam logic signed [9:0] SHIFT_BIAS = 10'(150 - FRAC_BITS);
    // A 24 bit mantissa fits 31 bits up to this left shift
    localparam logic signed [9:0] MAX_LEFT = 10'sd7;
    localparam logic signed [9:0] MIN_RIGHT = -10'sd24;
    localparam fixed_word_t FIXED_MAX = 32'sh7fff_ffff;
    localparam fixed_word_t FIXED_MIN = 32'sh8000_0000;

    logic signed [9:0] shift;
    logic signed [9:0] shift_neg;
    logic              s1_sign;
    logic [23:0]       s1_mant;
    logic              s1_left;
    logic [4:0]        s1_amount;
    logic              s1_sat;
    logic              s1_zero;
    logic [31:0]       mant_wide;
    fixed_word_t       magnitude;
    fixed_word_t       result;

    ////////////////////////////////////////
    // Stage 1, field decode and shift amount
    ////////////////////////////////////////
    assign shift = $signed({2'b00, in_word.fields.exponent}) - SHIFT_BIAS;
    assign shift_neg = -shift;

    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            s1_sign   <= in_word.fields.sign;
            s1_mant   <= {1'b1, in_word.fields.mantissa};
            s1_left   <= !shift[9];
            s1_amount <= shift[9] ? shift_neg[4:0] : shift[4:0];
            s1_sat    <= (in_word.fields.exponent == 8'hff) || (shift > MAX_LEFT);
            s1_zero   <= (in_word.fields.exponent == 8'h00) || (shift <= MIN_RIGHT);
        end
    end

    ////////////////////////////////////////
    // Stage 2, shift, sign and saturation
    ////////////////////////////////////////
    assign mant_wide = {8'h00, s1_mant};

    always_comb
    begin
        if (s1_left)
            magnitude = mant_wide << s1_amount;
        else
            magnitude = mant_wide >> s1_amount;

        if (s1_sat)
            result = s1_sign ? FIXED_MIN : FIXED_MAX;
        else if (s1_zero)
            result = '0;
        else if (s1_sign)
            result = -magnitude;
        else
            result = magnitude;
    end

    always_ff @(posedge aclk)
    begin
        if (ce)
            out_word <= result;
    end

endmodule

/* hw/raster_config.svh */
////////////////////////////////////////
// Build-time sizes of the fragment front end
// Index width must hold screen width times line count
// Fraction bits must stay below 31 for the signed result
// Colour fraction bits must be at least the sub-pixel width
////////////////////////////////////////
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// Screen geometry
`define RASTER_SCREEN_WIDTH      640
`define RASTER_SCREEN_POS_WIDTH  11
`define RASTER_INDEX_WIDTH       20

// Colour channel width after saturation
`define RASTER_SUB_PIXEL_WIDTH   8

// Fixed-point formats of the pixel pipeline
`define RASTER_TEX_FRAC_BITS     15   // S16.15
`define RASTER_DEPTH_FRAC_BITS   16   // Q16.16

// Colour before saturation, 1.0 is bit 16
`define RASTER_COLOR_FRAC_BITS   16

`endif

/* hw/raster_ctrl_pkg.sv */
////////////////////////////////////////
// Control state of the span sequencer
// Idle waits for a span, walk streams its fragments
////////////////////////////////////////

package raster_ctrl_pkg;

    // Span sequencer states
    typedef enum logic {
        SPAN_IDLE = 1'b0,
        SPAN_WALK = 1'b1
    } span_state_e;

endpackage

/* hw/raster_fragment_top.sv */
////////////////////////////////////////
// Fragment front end, sequencer and converter
// Whole pipeline stalls while m_ready is low
////////////////////////////////////////
`timescale 1ns/1ns
`include "raster_config.svh"

module raster_fragment_top
(
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           span_start,
    input  raster_types_pkg::screen_pos_t  span_x,
    input  raster_types_pkg::screen_pos_t  span_y,
    input  raster_types_pkg::screen_pos_t  span_len,
    output logic                           span_busy,
    input  logic                           s_valid,
    output logic                           s_ready,
    input  raster_types_pkg::float_word_u  s_depth_z,
    input  raster_types_pkg::float_word_u  s_tex_s,
    input  raster_types_pkg::float_word_u  s_tex_t,
    input  raster_types_pkg::float_word_u  s_color_r,
    input  raster_types_pkg::float_word_u  s_color_g,
    input  raster_types_pkg::float_word_u  s_color_b,
    input  raster_types_pkg::float_word_u  s_color_a,
    output logic                           m_valid,
    input  logic                           m_ready,
    output raster_types_pkg::screen_pos_t  m_x,
    output raster_types_pkg::screen_pos_t  m_y,
    output logic [`RASTER_INDEX_WIDTH-1:0] m_index,
    output logic                           m_last,
    output raster_types_pkg::fixed_word_t  m_depth_z,
    output raster_types_pkg::fixed_word_t  m_tex_s,
    output raster_types_pkg::fixed_word_t  m_tex_t,
    output raster_types_pkg::sub_pixel_t   m_color_r,
    output raster_types_pkg::sub_pixel_t   m_color_g,
    output raster_types_pkg::sub_pixel_t   m_color_b,
    output raster_types_pkg::sub_pixel_t   m_color_a
);
    import raster_types_pkg::*;

    logic                           cnt_load;
    logic                           cnt_step;
    screen_pos_t                    cnt_x;
    logic                           cnt_last;
    logic                           conv_valid;
    screen_pos_t                    conv_x;
    screen_pos_t                    conv_y;
    logic [`RASTER_INDEX_WIDTH-1:0] conv_index;
    logic                           conv_last;

    span_sequencer i_span_sequencer (
        .aclk(aclk), .rst_n(rst_n),
        .span_start(span_start), .span_x(span_x), .span_y(span_y),
        .span_len(span_len), .span_busy(span_busy),
        .s_valid(s_valid), .s_ready(s_ready), .m_ready(m_ready),
        .cnt_x(cnt_x), .cnt_last(cnt_last), .cnt_load(cnt_load), .cnt_step(cnt_step),
        .conv_valid(conv_valid), .conv_x(conv_x), .conv_y(conv_y),
        .conv_index(conv_index), .conv_last(conv_last)
    );

    span_pixel_counter i_span_pixel_counter (
        .aclk(aclk), .rst_n(rst_n),
        .cnt_load(cnt_load), .cnt_step(cnt_step),
        .load_x(span_x), .load_len(span_len),
        .cnt_x(cnt_x), .cnt_last(cnt_last)
    );

    // Downstream ready is the pipeline clock enable
    attribute_converter i_attribute_converter (
        .aclk(aclk), .rst_n(rst_n), .ce(m_ready),
        .in_valid(conv_valid), .in_x(conv_x), .in_y(conv_y),
        .in_index(conv_index), .in_last(conv_last),
        .in_depth_z(s_depth_z), .in_tex_s(s_tex_s), .in_tex_t(s_tex_t),
        .in_color_r(s_color_r), .in_color_g(s_color_g),
        .in_color_b(s_color_b), .in_color_a(s_color_a),
        .out_valid(m_valid), .out_x(m_x), .out_y(m_y),
        .out_index(m_index), .out_last(m_last),
        .out_depth_z(m_depth_z), .out_tex_s(m_tex_s), .out_tex_t(m_tex_t),
        .out_color_r(m_color_r), .out_color_g(m_color_g),
        .out_color_b(m_color_b), .out_color_a(m_color_a)
    );

endmodule

/* hw/raster_types_pkg.sv */
////////////////////////////////////////
// Arithmetic formats of the fragment front end
// Floats are IEEE-754 single precision, no denormal support
// Fixed words are 32 bit two's complement
////////////////////////////////////////
`include "raster_config.svh"

package raster_types_pkg;

    // Field view of a single-precision float
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } float_fields_s;

    // One float word, read either raw or split into fields
    typedef union packed {
        logic [31:0]   bits;
        float_fields_s fields;
    } float_word_u;

    // Signed fixed-point result, fraction position set per use
    typedef logic signed [31:0] fixed_word_t;

    // Saturated colour channel
    typedef logic [`RASTER_SUB_PIXEL_WIDTH-1:0] sub_pixel_t;

    // Screen coordinate, also used for span lengths
    typedef logic [`RASTER_SCREEN_POS_WIDTH-1:0] screen_pos_t;

endpackage

/* hw/span_pixel_counter.sv */
////////////////////////////////////////
// Position and remaining count of a span
// cnt_last flags the final pixel
////////////////////////////////////////
`timescale 1ns/1ns

module span_pixel_counter
(
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          cnt_load,
    input  logic                          cnt_step,
    input  raster_types_pkg::screen_pos_t load_x,
    input  raster_types_pkg::screen_pos_t load_len,
    output raster_types_pkg::screen_pos_t cnt_x,
    output logic                          cnt_last
);
    import raster_types_pkg::*;

    screen_pos_t remaining;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_x     <= '0;
            remaining <= '0;
        end
        else if (cnt_load)
        begin
            cnt_x     <= load_x;
            remaining <= load_len;
        end
        else if (cnt_step)
        begin
            cnt_x     <= cnt_x + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    assign cnt_last = (remaining == screen_pos_t'(1));

    // Sequencer must stop stepping at the end of a span
    step_in_span : assert property (
        @(posedge aclk) disable iff (!rst_n) cnt_step |-> (remaining != '0)
    );

endmodule

/* hw/span_sequencer.sv */
////////////////////////////////////////
// Accepts spans and stamps their fragments
// span_start is ignored while span_busy is high
// span_len must be at least 1
// Stream ready follows m_ready only while walking
////////////////////////////////////////
`timescale 1ns/1ns
`include "raster_config.svh"

module span_sequencer
(
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           span_start,
    input  raster_types_pkg::screen_pos_t  span_x,
    input  raster_types_pkg::screen_pos_t  span_y,
    input  raster_types_pkg::screen_pos_t  span_len,
    output logic                           span_busy,
    input  logic                           s_valid,
    output logic                           s_ready,
    input  logic                           m_ready,
    input  raster_types_pkg::screen_pos_t  cnt_x,
    input  logic                           cnt_last,
    output logic                           cnt_load,
    output logic                           cnt_step,
    output logic                           conv_valid,
    output raster_types_pkg::screen_pos_t  conv_x,
    output raster_types_pkg::screen_pos_t  conv_y,
    output logic [`RASTER_INDEX_WIDTH-1:0] conv_index,
    output logic                           conv_last
);
    import raster_types_pkg::*;
    import raster_ctrl_pkg::*;

    localparam int INDEX_W = `RASTER_INDEX_WIDTH;

    span_state_e state;
    screen_pos_t span_y_q;
    logic        accept;

    assign span_busy = (state == SPAN_WALK);
    assign s_ready = span_busy && m_ready;
    assign accept = s_valid && s_ready;
    assign cnt_load = span_start && (state == SPAN_IDLE);
    assign cnt_step = accept;

    // Fragment stamp, valid in the accept cycle
    assign conv_valid = accept;
    assign conv_x = cnt_x;
    assign conv_y = span_y_q;
    assign conv_last = cnt_last;
    assign conv_index = INDEX_W'(span_y_q * `RASTER_SCREEN_WIDTH + cnt_x);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            state <= SPAN_IDLE;
        else
        begin
            case (state)
                SPAN_IDLE:
                    if (span_start)
                        state <= SPAN_WALK;
                SPAN_WALK:
                    if (accept && cnt_last)
                        state <= SPAN_IDLE;
                default:
                    state <= SPAN_IDLE;
            endcase
        end
    end

    // Row of the active span
    always_ff @(posedge aclk)
    begin
        if (cnt_load)
            span_y_q <= span_y;
    end

    start_when_idle : assert property (
        @(posedge aclk) disable iff (!rst_n) span_start |-> !span_busy
    );

    // Span must be non-empty and begin on screen
    span_on_screen : assert property (
        @(posedge aclk) disable iff (!rst_n)
        span_start |-> (span_len != '0) && (span_x < `RASTER_SCREEN_WIDTH)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fragment front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_raster_fragment
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f flist.f -Mdir obj_dir -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verif/tb_raster_fragment.sv */
////////////////////////////////////////
// Testbench of the fragment front end
// Expected values come from a float model of the rules
// Latency is checked in cycles with m_ready high
// Random stimulus keeps exponents near the fixed range
////////////////////////////////////////
`timescale 1ns/1ns
`include "raster_config.svh"

module tb_raster_fragment;
    import raster_types_pkg::*;

    // About twice the cycles that all tests need
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int INDEX_W = `RASTER_INDEX_WIDTH;

    typedef struct packed {
        screen_pos_t        x;
        screen_pos_t        y;
        logic [INDEX_W-1:0] index;
        logic               last;
        fixed_word_t        depth_z;
        fixed_word_t        tex_s;
        fixed_word_t        tex_t;
        sub_pixel_t         color_r;
        sub_pixel_t         color_g;
        sub_pixel_t         color_b;
        sub_pixel_t         color_a;
        logic [31:0]        stamp;
    } expect_s;

    logic               aclk;
    logic               rst_n;
    logic               span_start;
    screen_pos_t        span_x;
    screen_pos_t        span_y;
    screen_pos_t        span_len;
    logic               span_busy;
    logic               s_valid;
    logic               s_ready;
    float_word_u        s_depth_z;
    float_word_u        s_tex_s;
    float_word_u        s_tex_t;
    float_word_u        s_color_r;
    float_word_u        s_color_g;
    float_word_u        s_color_b;
    float_word_u        s_color_a;
    logic               m_valid;
    logic               m_ready = 1'b1;
    screen_pos_t        m_x;
    screen_pos_t        m_y;
    logic [INDEX_W-1:0] m_index;
    logic               m_last;
    fixed_word_t        m_depth_z;
    fixed_word_t        m_tex_s;
    fixed_word_t        m_tex_t;
    sub_pixel_t         m_color_r;
    sub_pixel_t         m_color_g;
    sub_pixel_t         m_color_b;
    sub_pixel_t         m_color_a;

    int          seed = 99;
    int          ready_seed = 100;
    bit          bp_mode = 1'b0;
    string       test_name = "reset";
    int          errors = 0;
    int          checked = 0;
    int          sent = 0;
    int          cycle_count;
    logic [31:0] en_count = '0;
    int          model_x;
    int          model_y;
    int          model_len;
    int          ordinal;
    bit          busy_rise_due = 1'b0;
    bit          busy_fall_due = 1'b0;
    expect_s     exp_q[$];

    // Exact values, then specials, then colour values
    logic [31:0] float_table [20] = '{
        32'h3f80_0000, 32'h3f00_0000, 32'hc010_0000, 32'h42c8_0000,
        32'h5015_02f9, 32'hd015_02f9, 32'h7f80_0000, 32'hff80_0000,
        32'h7fc0_0000, 32'h0000_0000, 32'h8000_0000, 32'h0000_0001,
        32'h4700_0000, 32'hc700_0000, 32'h2edb_e6ff, 32'h3fc0_0000,
        32'hbf00_0000, 32'h3f40_0000, 32'h3f7d_70a4, 32'h3b44_9ba6
    };

    raster_fragment_top i_raster_fragment_top (.*);

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Float times 2^frac, truncated toward zero, saturated by sign
    function automatic fixed_word_t to_fixed(input float_word_u w, input int frac);
        real mag;
        int  scale;
        int  i;
        if (w.fields.exponent == 8'hff)
            return w.fields.sign ? 32'sh8000_0000 : 32'sh7fff_ffff;
        if (w.fields.exponent == 8'h00)
            return '0;
        mag = real'({1'b1, w.fields.mantissa});
        scale = int'(w.fields.exponent) - 150 + frac;
        for (i = 0; i < scale; i++)
            mag = mag * 2.0;
        for (i = 0; i > scale; i--)
            mag = mag * 0.5;
        if (mag >= 2147483648.0)
            return w.fields.sign ? 32'sh8000_0000 : 32'sh7fff_ffff;
        return w.fields.sign ? -$rtoi(mag) : $rtoi(mag);
    endfunction

    function automatic sub_pixel_t expect_color(input float_word_u w);
        fixed_word_t fx;
        fx = to_fixed(w, `RASTER_COLOR_FRAC_BITS);
        if (fx[31:`RASTER_COLOR_FRAC_BITS] != '0)
            return '1;
        return fx[`RASTER_COLOR_FRAC_BITS-1 -: `RASTER_SUB_PIXEL_WIDTH];
    endfunction

    function automatic logic [31:0] rand_float();
        logic [31:0] r;
        r = $random(seed);
        return {r[31], 8'(110 + r[30:23] % 40), r[22:0]};
    endfunction

    function automatic logic [31:0] frag_word(input bit from_table, input int idx);
        if (from_table)
            return float_table[idx % 20];
        return rand_float();
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("Mismatch %s %s expected %h actual %h", test_name, field,
                     expected, actual);
        end
    endtask

    // Start a span, then feed its fragments until each is accepted
    task automatic send_span(input int x, input int y, input int len, input int base,
                             input bit from_table);
        int k;
        while (span_busy)
            @(posedge aclk);
        span_start <= 1'b1;
        span_x <= screen_pos_t'(x);
        span_y <= screen_pos_t'(y);
        span_len <= screen_pos_t'(len);
        @(posedge aclk);
        span_start <= 1'b0;
        for (k = 0; k < len; k++)
        begin
            s_valid <= 1'b1;
            s_depth_z <= frag_word(from_table, base + k);
            s_tex_s <= frag_word(from_table, base + k + 1);
            s_tex_t <= frag_word(from_table, base + k + 2);
            s_color_r <= frag_word(from_table, base + k + 3);
            s_color_g <= frag_word(from_table, base + k + 4);
            s_color_b <= frag_word(from_table, base + k + 5);
            s_color_a <= frag_word(from_table, base + k + 6);
            @(posedge aclk);
            while (!s_ready)
                @(posedge aclk);
        end
        s_valid <= 1'b0;
    endtask

    task automatic send_random_span(input int len);
        int x;
        int y;
        x = {$random(seed)} % (641 - len);
        y = {$random(seed)} % 480;
        send_span(x, y, len, 0, 1'b0);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || span_busy)
            @(posedge aclk);
    endtask

    always @(posedge aclk)
    begin
        if (bp_mode)
            m_ready <= ({$random(ready_seed)} % 3) != 0;
        else
            m_ready <= 1'b1;
    end

    ////////////////////////////////////////
    // Model update and output compare
    ////////////////////////////////////////
    always @(posedge aclk)
    begin
        expect_s e;
        int      x_val;
        if (rst_n)
        begin
            if (m_ready)
                en_count = en_count + 1;
            if (busy_rise_due && !span_busy)
            begin
                errors++;
                $display("span_busy did not rise after span_start in %s", test_name);
            end
            if (busy_fall_due && span_busy)
            begin
                errors++;
                $display("span_busy still high after the last fragment in %s", test_name);
            end
            busy_rise_due = 1'b0;
            busy_fall_due = 1'b0;
            if (s_ready && (!m_ready || !span_busy))
            begin
                errors++;
                $display("s_ready high while m_ready is low or no span is active in %s",
                         test_name);
            end
            if (m_valid && m_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Output fragment with nothing pending in %s", test_name);
                end
                else
                begin
                    e = exp_q.pop_front();
                    checked++;
                    check_value("m_x", e.x, m_x);
                    check_value("m_y", e.y, m_y);
                    check_value("m_index", e.index, m_index);
                    check_value("m_last", e.last, m_last);
                    check_value("m_depth_z", e.depth_z, m_depth_z);
                    check_value("m_tex_s", e.tex_s, m_tex_s);
                    check_value("m_tex_t", e.tex_t, m_tex_t);
                    check_value("m_color_r", e.color_r, m_color_r);
                    check_value("m_color_g", e.color_g, m_color_g);
                    check_value("m_color_b", e.color_b, m_color_b);
                    check_value("m_color_a", e.color_a, m_color_a);
                    check_value("latency", 32'd2, en_count - e.stamp);
                end
            end
            if (span_start && !span_busy)
            begin
                model_x = span_x;
                model_y = span_y;
                model_len = span_len;
                ordinal = 0;
                busy_rise_due = 1'b1;
            end
            if (s_valid && s_ready)
            begin
                x_val = model_x + ordinal;
                e.x = screen_pos_t'(x_val);
                e.y = screen_pos_t'(model_y);
                e.index = INDEX_W'(model_y * `RASTER_SCREEN_WIDTH + x_val);
                e.last = (ordinal == model_len - 1);
                e.depth_z = to_fixed(s_depth_z, `RASTER_DEPTH_FRAC_BITS);
                e.tex_s = to_fixed(s_tex_s, `RASTER_TEX_FRAC_BITS);
                e.tex_t = to_fixed(s_tex_t, `RASTER_TEX_FRAC_BITS);
                e.color_r = expect_color(s_color_r);
                e.color_g = expect_color(s_color_g);
                e.color_b = expect_color(s_color_b);
                e.color_a = expect_color(s_color_a);
                e.stamp = en_count;
                exp_q.push_back(e);
                sent++;
                busy_fall_due = e.last;
                ordinal++;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles in %s, errors %0d, checked %0d of %0d",
                 TIMEOUT_CYCLES, test_name, errors, checked, sent);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        int k;
        rst_n = 1'b0;
        span_start = 1'b0;
        span_x = '0;
        span_y = '0;
        span_len = '0;
        s_valid = 1'b0;
        s_depth_z = '0;
        s_tex_s = '0;
        s_tex_t = '0;
        s_color_r = '0;
        s_color_g = '0;
        s_color_b = '0;
        s_color_a = '0;
        repeat (2) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        if (m_valid || span_busy || s_ready)
        begin
            errors++;
            $display("m_valid, span_busy or s_ready not low after reset");
        end

        test_name = "exact_floats";
        send_span(10, 3, 4, 0, 1'b1);
        wait_drain();
        test_name = "special_cases";
        send_span(200, 50, 12, 4, 1'b1);
        wait_drain();
        test_name = "color_saturation";
        send_span(632, 479, 8, 12, 1'b1);
        wait_drain();

        test_name = "span_stamping";
        send_random_span(1);
        send_random_span(5);
        send_random_span(17);
        wait_drain();

        test_name = "random_backpressure";
        bp_mode <= 1'b1;
        for (k = 0; k < 6; k++)
            send_random_span(1 + {$random(seed)} % 20);
        wait_drain();
        bp_mode <= 1'b0;

        test_name = "latency";
        @(posedge aclk);
        send_random_span(8);
        wait_drain();
        repeat (2) @(posedge aclk);

        $display("Errors %0d, fragments checked %0d of %0d sent", errors, checked, sent);
        if (errors == 0 && checked == sent)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
